/* src/cpu_pkg.sv */
package cpu_pkg;

	localparam int XLEN = 32;

	//================================================
	// Opcodes of the supported subset

	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	//================================================
	// Function fields

	localparam logic [2:0] F3_ADD   = 3'b000;
	localparam logic [2:0] F3_XOR   = 3'b100;
	localparam logic [2:0] F3_OR    = 3'b110;
	localparam logic [2:0] F3_AND   = 3'b111;
	localparam logic [2:0] F3_CSRRW = 3'b001;
	localparam logic [2:0] F3_CSRRS = 3'b010;
	localparam logic [6:0] F7_SUB   = 7'b0100000;

	// Machine CSR addresses
	localparam logic [11:0] CSR_MSCRATCH = 12'h340;
	localparam logic [11:0] CSR_MINSTRET = 12'hB02;
	localparam logic [11:0] CSR_MHARTID  = 12'hF14;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASS_B
	} alu_op_e;

endpackage

/* src/cpu_skid_buffer.sv */
module cpu_skid_buffer #(
	parameter type payload_t = logic [2*cpu_pkg::XLEN-1:0]
)(
	input wire i_clock,
	input wire i_rst_n,
	input wire i_valid,
	input payload_t i_data,
	input wire i_busy,
	input wire i_flush,
	output logic o_valid,
	output payload_t o_data
);

	logic held_q;
	payload_t data_q;

	// Parked entry goes out first
	assign o_valid = held_q | i_valid;
	assign o_data = held_q ? data_q : i_data;

	always_ff @(posedge i_clock) begin
		if (!i_rst_n)
			held_q <= 1'b0;
		else if (i_flush)
			held_q <= 1'b0;
		else if (i_busy)
			held_q <= o_valid;
		else
			held_q <= held_q & i_valid;
	end

	always_ff @(posedge i_clock) begin
		if (!held_q || !i_busy)
			data_q <= i_data;
	end

endmodule

/* src/cpu_fetch.sv */
module cpu_fetch #(
	parameter logic [cpu_pkg::XLEN-1:0] RESET_VECTOR = '0
)(
	input wire i_clock,
	input wire i_rst_n,

	input wire i_jump,
	input wire [cpu_pkg::XLEN-1:0] i_jump_pc,
	input wire i_busy,

	output logic o_ibus_request,
	input wire i_ibus_ready,
	output logic [cpu_pkg::XLEN-1:0] o_ibus_address,
	input wire [cpu_pkg::XLEN-1:0] i_ibus_rdata,

	output logic o_valid,
	output logic [cpu_pkg::XLEN-1:0] o_pc,
	output logic [cpu_pkg::XLEN-1:0] o_instr
);
	import cpu_pkg::*;

	logic req_q;
	logic discard_q;
	logic [XLEN-1:0] pc_q;
	logic [XLEN-1:0] addr_q;
	logic [XLEN-1:0] next_pc;
	logic done;
	logic issue;

	assign done = req_q & i_ibus_ready;
	// One outstanding read at most
	assign issue = (!req_q || done) && !i_busy;
	assign next_pc = i_jump ? i_jump_pc : pc_q;

	assign o_ibus_request = req_q;
	assign o_ibus_address = addr_q;
	assign o_valid = done & !discard_q;
	assign o_pc = addr_q;
	assign o_instr = i_ibus_rdata;

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			req_q <= 1'b0;
			discard_q <= 1'b0;
			pc_q <= RESET_VECTOR;
		end else begin
			if (issue) begin
				req_q <= 1'b1;
				pc_q <= next_pc + XLEN'(4);
			end else begin
				if (done)
					req_q <= 1'b0;
				pc_q <= next_pc;
			end

			// Word still on the old path when the jump came
			if (done)
				discard_q <= 1'b0;
			else if (i_jump && req_q)
				discard_q <= 1'b1;
		end
	end

	// Address stays put until ready
	always_ff @(posedge i_clock) begin
		if (issue)
			addr_q <= next_pc;
	end

endmodule

/* src/cpu_registers.sv */
module cpu_registers #(
	parameter logic [cpu_pkg::XLEN-1:0] STACK_POINTER = '0
)(
	input wire i_clock,
	input wire i_rst_n,

	input wire [4:0] i_rs1_idx,
	input wire [4:0] i_rs2_idx,
	output logic [cpu_pkg::XLEN-1:0] o_rs1,
	output logic [cpu_pkg::XLEN-1:0] o_rs2,

	input wire i_wr,
	input wire [4:0] i_rd,
	input wire [cpu_pkg::XLEN-1:0] i_wdata
);
	import cpu_pkg::*;

	logic [XLEN-1:0] regs_q [1:31];

	// x0 never stored
	assign o_rs1 = (i_rs1_idx == 5'd0) ? '0 : regs_q[i_rs1_idx];
	assign o_rs2 = (i_rs2_idx == 5'd0) ? '0 : regs_q[i_rs2_idx];

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			for (int i = 1; i < 32; i++)
				regs_q[i] <= (i == 2) ? STACK_POINTER : '0;
		end else if (i_wr && i_rd != 5'd0) begin
			regs_q[i_rd] <= i_wdata;
		end
	end

endmodule

/* src/cpu_csr.sv */
module cpu_csr #(
	parameter logic [cpu_pkg::XLEN-1:0] HARTID = '0
)(
	input wire i_clock,
	input wire i_rst_n,

	input wire [11:0] i_index,
	input wire i_wr,
	input wire [cpu_pkg::XLEN-1:0] i_wdata,
	output logic [cpu_pkg::XLEN-1:0] o_rdata,

	input wire i_retire
);
	import cpu_pkg::*;

	logic [XLEN-1:0] mscratch_q;
	logic [XLEN-1:0] minstret_q;

	always_comb begin
		case (i_index)
			CSR_MSCRATCH: o_rdata = mscratch_q;
			CSR_MINSTRET: o_rdata = minstret_q;
			CSR_MHARTID:  o_rdata = HARTID;
			default:      o_rdata = '0;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			mscratch_q <= '0;
			minstret_q <= '0;
		end else begin
			if (i_wr && i_index == CSR_MSCRATCH)
				mscratch_q <= i_wdata;

			// Software write wins over the count
			if (i_wr && i_index == CSR_MINSTRET)
				minstret_q <= i_wdata;
			else if (i_retire)
				minstret_q <= minstret_q + XLEN'(1);
		end
	end

endmodule

/* src/cpu_execute.sv */
module cpu_execute (
	input wire i_clock,
	input wire i_rst_n,

	input wire i_valid,
	input wire [cpu_pkg::XLEN-1:0] i_pc,
	input wire [cpu_pkg::XLEN-1:0] i_instr,
	output logic o_busy,

	output logic [4:0] o_rs1_idx,
	output logic [4:0] o_rs2_idx,
	input wire [cpu_pkg::XLEN-1:0] i_rs1,
	input wire [cpu_pkg::XLEN-1:0] i_rs2,

	input wire i_mem_busy,
	input wire i_mem_valid,
	input wire [4:0] i_mem_rd,

	output logic o_jump,
	output logic [cpu_pkg::XLEN-1:0] o_jump_pc,

	output logic [11:0] o_csr_index,
	output logic o_csr_wr,
	output logic [cpu_pkg::XLEN-1:0] o_csr_wdata,
	input wire [cpu_pkg::XLEN-1:0] i_csr_rdata,

	output logic o_valid,
	output logic [4:0] o_rd,
	output logic [cpu_pkg::XLEN-1:0] o_result,
	output logic [cpu_pkg::XLEN-1:0] o_store_data,
	output logic o_mem_read,
	output logic o_mem_write,
	output logic o_fault
);
	import cpu_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
	alu_op_e alu_op;
	logic [XLEN-1:0] operand_b;
	logic [XLEN-1:0] alu_out;
	logic uses_rs1, uses_rs2, writes_rd;
	logic is_load, is_store, is_branch, is_jal, is_csr, illegal;
	logic hazard, fire, fault_q;

	function automatic alu_op_e funct3_op(input logic [2:0] f3, input logic sub);
		case (f3)
			F3_ADD:  return sub ? ALU_SUB : ALU_ADD;
			F3_XOR:  return ALU_XOR;
			F3_OR:   return ALU_OR;
			F3_AND:  return ALU_AND;
			default: return ALU_ADD;
		endcase
	endfunction

	assign opcode = i_instr[6:0];
	assign funct3 = i_instr[14:12];
	assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
	assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
	assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
		i_instr[11:8], 1'b0};
	assign imm_u = {i_instr[31:12], 12'b0};
	assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
		i_instr[30:21], 1'b0};

	//================================================
	// Decode

	always_comb begin
		alu_op = ALU_ADD;
		operand_b = i_rs2;
		{uses_rs1, uses_rs2, writes_rd} = 3'b000;
		{is_load, is_store, is_branch, is_jal, is_csr, illegal} = 6'b0;
		case (opcode)
			OPC_LUI: begin
				alu_op = ALU_PASS_B;
				operand_b = imm_u;
				writes_rd = 1'b1;
			end
			OPC_OPIMM: begin
				alu_op = funct3_op(funct3, 1'b0);
				operand_b = imm_i;
				{uses_rs1, writes_rd} = 2'b11;
			end
			OPC_OP: begin
				alu_op = funct3_op(funct3, i_instr[31:25] == F7_SUB);
				{uses_rs1, uses_rs2, writes_rd} = 3'b111;
			end
			OPC_LOAD: begin
				operand_b = imm_i;
				{uses_rs1, writes_rd, is_load} = 3'b111;
			end
			OPC_STORE: begin
				operand_b = imm_s;
				{uses_rs1, uses_rs2, is_store} = 3'b111;
			end
			OPC_BRANCH: {uses_rs1, uses_rs2, is_branch} = 3'b111;
			OPC_JAL:    {writes_rd, is_jal} = 2'b11;
			OPC_SYSTEM: {uses_rs1, writes_rd, is_csr} = 3'b111;
			default:    illegal = 1'b1;
		endcase
	end

	always_comb begin
		case (alu_op)
			ALU_SUB:    alu_out = i_rs1 - operand_b;
			ALU_AND:    alu_out = i_rs1 & operand_b;
			ALU_OR:     alu_out = i_rs1 | operand_b;
			ALU_XOR:    alu_out = i_rs1 ^ operand_b;
			ALU_PASS_B: alu_out = operand_b;
			default:    alu_out = i_rs1 + operand_b;
		endcase
	end

	//================================================
	// Interlock

	assign o_rs1_idx = i_instr[19:15];
	assign o_rs2_idx = i_instr[24:20];

	// CSR access waits for an empty memory stage so minstret is exact
	assign hazard = i_mem_valid && (is_csr
		|| (uses_rs1 && o_rs1_idx != 5'd0 && o_rs1_idx == i_mem_rd)
		|| (uses_rs2 && o_rs2_idx != 5'd0 && o_rs2_idx == i_mem_rd));

	assign o_busy = fault_q | (i_valid & (hazard | i_mem_busy));
	assign fire = i_valid & !o_busy;

	assign o_jump = fire & (is_jal | (is_branch & (i_rs1 == i_rs2)));
	assign o_jump_pc = i_pc + (is_jal ? imm_j : imm_b);

	assign o_csr_index = i_instr[31:20];
	assign o_csr_wr = fire & is_csr;
	assign o_csr_wdata = (funct3 == F3_CSRRS) ? (i_csr_rdata | i_rs1) : i_rs1;

	assign o_valid = fire & !illegal;
	assign o_rd = writes_rd ? i_instr[11:7] : 5'd0;
	assign o_result = is_jal ? i_pc + XLEN'(4) : (is_csr ? i_csr_rdata : alu_out);
	assign o_store_data = i_rs2;
	assign o_mem_read = is_load;
	assign o_mem_write = is_store;
	assign o_fault = fault_q;

	// Halts the core until reset
	always_ff @(posedge i_clock) begin
		if (!i_rst_n)
			fault_q <= 1'b0;
		else if (fire && illegal)
			fault_q <= 1'b1;
	end

endmodule

/* src/cpu_memory.sv */
module cpu_memory (
	input wire i_clock,
	input wire i_rst_n,

	input wire i_valid,
	input wire [4:0] i_rd,
	input wire [cpu_pkg::XLEN-1:0] i_result,
	input wire [cpu_pkg::XLEN-1:0] i_store_data,
	input wire i_mem_read,
	input wire i_mem_write,
	output logic o_busy,
	output logic o_valid,
	output logic [4:0] o_rd,

	output logic o_dbus_request,
	output logic o_dbus_rw,
	input wire i_dbus_ready,
	output logic [cpu_pkg::XLEN-1:0] o_dbus_address,
	input wire [cpu_pkg::XLEN-1:0] i_dbus_rdata,
	output logic [cpu_pkg::XLEN-1:0] o_dbus_wdata,

	output logic o_reg_wr,
	output logic [4:0] o_reg_rd,
	output logic [cpu_pkg::XLEN-1:0] o_reg_wdata,
	output logic o_retire
);
	import cpu_pkg::*;

	logic valid_q;
	logic read_q, write_q;
	logic [4:0] rd_q;
	logic [XLEN-1:0] result_q;
	logic [XLEN-1:0] store_q;
	logic access;
	logic done;

	assign access = read_q | write_q;
	assign done = valid_q & (!access | i_dbus_ready);

	assign o_busy = valid_q & access & !i_dbus_ready;
	assign o_valid = valid_q;
	assign o_rd = rd_q;

	// rw high means write
	assign o_dbus_request = valid_q & access;
	assign o_dbus_rw = write_q;
	assign o_dbus_address = result_q;
	assign o_dbus_wdata = store_q;

	assign o_reg_wr = done & !write_q & (rd_q != 5'd0);
	assign o_reg_rd = rd_q;
	assign o_reg_wdata = read_q ? i_dbus_rdata : result_q;
	assign o_retire = done;

	always_ff @(posedge i_clock) begin
		if (!i_rst_n)
			valid_q <= 1'b0;
		else if (!o_busy)
			valid_q <= i_valid;
	end

	always_ff @(posedge i_clock) begin
		if (!o_busy) begin
			read_q <= i_mem_read;
			write_q <= i_mem_write;
			rd_q <= i_rd;
			result_q <= i_result;
			store_q <= i_store_data;
		end
	end

endmodule

/* src/cpu.sv */
module cpu #(
	parameter logic [cpu_pkg::XLEN-1:0] RESET_VECTOR = 32'h0000_0000,
	parameter logic [cpu_pkg::XLEN-1:0] STACK_POINTER = 32'h1000_0400,
	parameter logic [cpu_pkg::XLEN-1:0] HARTID = 32'h0000_0000
)(
	input wire i_clock,
	input wire i_rst_n,

	// Instruction bus
	output wire o_ibus_request,
	input wire i_ibus_ready,
	output wire [cpu_pkg::XLEN-1:0] o_ibus_address,
	input wire [cpu_pkg::XLEN-1:0] i_ibus_rdata,

	// Data bus
	output wire o_dbus_request,
	output wire o_dbus_rw,
	input wire i_dbus_ready,
	output wire [cpu_pkg::XLEN-1:0] o_dbus_address,
	input wire [cpu_pkg::XLEN-1:0] i_dbus_rdata,
	output wire [cpu_pkg::XLEN-1:0] o_dbus_wdata,

	// Debug
	output wire o_retire,
	output wire o_execute_busy,
	output wire o_memory_busy,
	output wire o_fault
);
	import cpu_pkg::*;

	// PC in the upper half, instruction word in the lower
	typedef logic [2*XLEN-1:0] fetch_pair_t;

	//================================================
	// Stage to stage wires

	wire fetch_valid;
	wire [XLEN-1:0] fetch_pc;
	wire [XLEN-1:0] fetch_instr;
	wire skid_valid;
	fetch_pair_t skid_data;

	wire execute_jump;
	wire [XLEN-1:0] execute_jump_pc;
	wire execute_valid;
	wire [4:0] execute_rd;
	wire [XLEN-1:0] execute_result;
	wire [XLEN-1:0] execute_store_data;
	wire execute_mem_read, execute_mem_write;

	wire memory_valid;
	wire [4:0] memory_rd;

	wire [4:0] rs1_idx, rs2_idx;
	wire [XLEN-1:0] rs1, rs2;
	wire reg_wr;
	wire [4:0] reg_rd;
	wire [XLEN-1:0] reg_wdata;

	wire [11:0] csr_index;
	wire csr_wr;
	wire [XLEN-1:0] csr_wdata, csr_rdata;

	//================================================
	// Fetch

	cpu_fetch #(
		.RESET_VECTOR(RESET_VECTOR)
	) fetch (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_jump(execute_jump),
		.i_jump_pc(execute_jump_pc),
		.i_busy(o_execute_busy),
		.o_ibus_request(o_ibus_request),
		.i_ibus_ready(i_ibus_ready),
		.o_ibus_address(o_ibus_address),
		.i_ibus_rdata(i_ibus_rdata),
		.o_valid(fetch_valid),
		.o_pc(fetch_pc),
		.o_instr(fetch_instr)
	);

	cpu_skid_buffer #(
		.payload_t(fetch_pair_t)
	) fetch_skid (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_valid(fetch_valid),
		.i_data({fetch_pc, fetch_instr}),
		.i_busy(o_execute_busy),
		.i_flush(execute_jump),
		.o_valid(skid_valid),
		.o_data(skid_data)
	);

	//================================================
	// Register file and CSR

	cpu_registers #(
		.STACK_POINTER(STACK_POINTER)
	) registers (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_rs1_idx(rs1_idx),
		.i_rs2_idx(rs2_idx),
		.o_rs1(rs1),
		.o_rs2(rs2),
		.i_wr(reg_wr),
		.i_rd(reg_rd),
		.i_wdata(reg_wdata)
	);

	cpu_csr #(
		.HARTID(HARTID)
	) csr (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_index(csr_index),
		.i_wr(csr_wr),
		.i_wdata(csr_wdata),
		.o_rdata(csr_rdata),
		.i_retire(o_retire)
	);

	//================================================
	// Execute

	cpu_execute execute (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_valid(skid_valid),
		.i_pc(skid_data[2*XLEN-1:XLEN]),
		.i_instr(skid_data[XLEN-1:0]),
		.o_busy(o_execute_busy),
		.o_rs1_idx(rs1_idx),
		.o_rs2_idx(rs2_idx),
		.i_rs1(rs1),
		.i_rs2(rs2),
		.i_mem_busy(o_memory_busy),
		.i_mem_valid(memory_valid),
		.i_mem_rd(memory_rd),
		.o_jump(execute_jump),
		.o_jump_pc(execute_jump_pc),
		.o_csr_index(csr_index),
		.o_csr_wr(csr_wr),
		.o_csr_wdata(csr_wdata),
		.i_csr_rdata(csr_rdata),
		.o_valid(execute_valid),
		.o_rd(execute_rd),
		.o_result(execute_result),
		.o_store_data(execute_store_data),
		.o_mem_read(execute_mem_read),
		.o_mem_write(execute_mem_write),
		.o_fault(o_fault)
	);

	//================================================
	// Memory and writeback

	cpu_memory memory (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_valid(execute_valid),
		.i_rd(execute_rd),
		.i_result(execute_result),
		.i_store_data(execute_store_data),
		.i_mem_read(execute_mem_read),
		.i_mem_write(execute_mem_write),
		.o_busy(o_memory_busy),
		.o_valid(memory_valid),
		.o_rd(memory_rd),
		.o_dbus_request(o_dbus_request),
		.o_dbus_rw(o_dbus_rw),
		.i_dbus_ready(i_dbus_ready),
		.o_dbus_address(o_dbus_address),
		.i_dbus_rdata(i_dbus_rdata),
		.o_dbus_wdata(o_dbus_wdata),
		.o_reg_wr(reg_wr),
		.o_reg_rd(reg_rd),
		.o_reg_wdata(reg_wdata),
		.o_retire(o_retire)
	);

endmodule

/* bench/cpu_tb.sv */
module cpu_tb;
	import cpu_pkg::*;

	localparam logic [31:0] RESET_VECTOR = 32'h0000_0100;
	localparam logic [31:0] STACK_POINTER = 32'h1000_0400;
	localparam logic [31:0] HARTID = 32'h0000_0005;

	logic i_clock, i_rst_n;
	logic i_ibus_ready, i_dbus_ready;
	logic [31:0] i_ibus_rdata, i_dbus_rdata;
	wire o_ibus_request, o_dbus_request, o_dbus_rw;
	wire [31:0] o_ibus_address, o_dbus_address, o_dbus_wdata;
	wire o_retire, o_execute_busy, o_memory_busy, o_fault;

	logic [31:0] lfsr;
	logic [31:0] imem [0:63];
	int prog_len;
	logic [31:0] jal_addr;
	logic [31:0] dmem [logic [31:0]];
	logic [31:0] model_mem [logic [31:0]];
	logic [31:0] exp_rw [$];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	int exp_retire_end, retire_seen, retire_at_end, jal_hits;
	bit first_fetch_seen, stores_done, in_loop;
	bit ibus_pending, dbus_pending;
	logic [1:0] ibus_wait, dbus_wait;

	cpu #(
		.RESET_VECTOR(RESET_VECTOR),
		.STACK_POINTER(STACK_POINTER),
		.HARTID(HARTID)
	) u_cpu (
		.i_clock(i_clock), .i_rst_n(i_rst_n),
		.o_ibus_request(o_ibus_request), .i_ibus_ready(i_ibus_ready),
		.o_ibus_address(o_ibus_address), .i_ibus_rdata(i_ibus_rdata),
		.o_dbus_request(o_dbus_request), .o_dbus_rw(o_dbus_rw),
		.i_dbus_ready(i_dbus_ready), .o_dbus_address(o_dbus_address),
		.i_dbus_rdata(i_dbus_rdata), .o_dbus_wdata(o_dbus_wdata),
		.o_retire(o_retire), .o_execute_busy(o_execute_busy),
		.o_memory_busy(o_memory_busy), .o_fault(o_fault)
	);

	always #10 i_clock = ~i_clock;

	//==================================================
	// Helpers

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act)
			stop_on_error($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
	endtask

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return r;
	endfunction

	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return addr ^ {addr[15:0], addr[31:16]} ^ 32'h3c96_a55a;
	endfunction

	// Outside the program every word has opcode 0 and is illegal
	function automatic logic [31:0] word_at(input logic [31:0] addr);
		logic [31:0] idx;
		idx = (addr - RESET_VECTOR) >> 2;
		if (idx < prog_len)
			return imem[idx];
		return {addr[31:7], 7'h00};
	endfunction

	function automatic logic [31:0] read_dmem(input logic [31:0] addr);
		return dmem.exists(addr) ? dmem[addr] : fill_word(addr);
	endfunction

	task automatic emit(input logic [31:0] w);
		imem[prog_len] = w;
		prog_len++;
	endtask

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic logic [31:0] enc_sw(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
	endfunction

	//==================================================
	// Program generation

	task automatic build_main_program();
		logic [2:0] sel;
		logic [4:0] rd, rs1, rs2;
		logic [11:0] imm;
		prog_len = 0;
		for (int r = 1; r < 8; r++) begin
			if (r != 2) begin
				emit({20'(rand_bits(20)), 5'(r), OPC_LUI});
				emit(enc_i(12'(rand_bits(12)), 5'(r), F3_ADD, 5'(r), OPC_OPIMM));
			end
		end
		// x2 still holds its reset value here
		emit(enc_sw(12'h3fc, 5'd2, 5'd0));
		for (int k = 0; k < 16; k++) begin
			sel = 3'(rand_bits(3));
			rd = 5'(rand_bits(3));
			rs1 = 5'(rand_bits(3));
			rs2 = 5'(rand_bits(3));
			imm = 12'(rand_bits(12));
			case (sel)
				3'd0: emit(enc_i(imm, rs1, F3_ADD, rd, OPC_OPIMM));
				3'd1: emit(enc_r(7'd0, rs2, rs1, F3_ADD, rd));
				3'd2: emit(enc_r(F7_SUB, rs2, rs1, F3_ADD, rd));
				3'd3: emit(enc_r(7'd0, rs2, rs1, F3_AND, rd));
				3'd4: emit(enc_r(7'd0, rs2, rs1, F3_OR, rd));
				3'd5: emit(enc_r(7'd0, rs2, rs1, F3_XOR, rd));
				3'd6: emit(enc_i(imm, rs1, F3_XOR, rd, OPC_OPIMM));
				default: emit(enc_i(imm, rs1, F3_OR, rd, OPC_OPIMM));
			endcase
		end
		emit(enc_sw(12'h500, 5'd3, 5'd0));
		emit(enc_i(12'h500, 5'd0, 3'b010, 5'd4, OPC_LOAD));
		// BEQ x5, x5, +8 jumps over the poison ADDI
		emit({1'b0, 6'd0, 5'd5, 5'd5, 3'b000, 4'b0100, 1'b0, OPC_BRANCH});
		emit(enc_i(12'h123, 5'd1, F3_ADD, 5'd1, OPC_OPIMM));
		emit(enc_i(CSR_MSCRATCH, 5'd1, F3_CSRRW, 5'd7, OPC_SYSTEM));
		emit(enc_i(CSR_MSCRATCH, 5'd0, F3_CSRRS, 5'd6, OPC_SYSTEM));
		emit(enc_i(CSR_MINSTRET, 5'd0, F3_CSRRS, 5'd5, OPC_SYSTEM));
		emit(enc_i(CSR_MHARTID, 5'd0, F3_CSRRS, 5'd3, OPC_SYSTEM));
		for (int r = 1; r < 8; r++)
			emit(enc_sw(12'h400 + 12'(4 * r), 5'(r), 5'd0));
		jal_addr = RESET_VECTOR + 32'(4 * prog_len);
		emit({20'd0, 5'd0, OPC_JAL});
	endtask

	//==================================================
	// Golden model

	task automatic run_model();
		logic [31:0] regs [0:31];
		logic [31:0] pc, w, a, b, res, addr, csr_old, mscratch;
		logic [31:0] imm_i, imm_s, imm_b, imm_j;
		int retired;
		bit done;
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		regs[2] = STACK_POINTER;
		pc = RESET_VECTOR;
		mscratch = '0;
		retired = 0;
		done = 0;
		for (int step = 0; step < 500 && !done; step++) begin
			w = word_at(pc);
			a = regs[w[19:15]];
			b = regs[w[24:20]];
			imm_i = {{20{w[31]}}, w[31:20]};
			imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
			imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
			imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			res = '0;
			if (w[6:0] == OPC_OPIMM)
				b = imm_i;
			case (w[6:0])
				OPC_LUI: res = {w[31:12], 12'd0};
				OPC_OPIMM, OPC_OP: begin
					case (w[14:12])
						F3_XOR: res = a ^ b;
						F3_OR: res = a | b;
						F3_AND: res = a & b;
						default: res = (w[6:0] == OPC_OP && w[30]) ? a - b : a + b;
					endcase
				end
				OPC_LOAD: begin
					addr = a + imm_i;
					res = model_mem.exists(addr) ? model_mem[addr] : fill_word(addr);
					exp_rw.push_back(0);
					exp_addr.push_back(addr);
					exp_data.push_back('0);
				end
				OPC_STORE: begin
					addr = a + imm_s;
					model_mem[addr] = b;
					exp_rw.push_back(1);
					exp_addr.push_back(addr);
					exp_data.push_back(b);
					exp_retire_end = retired + 1;
				end
				OPC_SYSTEM: begin
					case (w[31:20])
						CSR_MSCRATCH: csr_old = mscratch;
						CSR_MINSTRET: csr_old = retired;
						CSR_MHARTID: csr_old = HARTID;
						default: csr_old = '0;
					endcase
					if (w[31:20] == CSR_MSCRATCH)
						mscratch = (w[14:12] == F3_CSRRS) ? (csr_old | a) : a;
					res = csr_old;
				end
				OPC_BRANCH, OPC_JAL: res = pc + 4;
				default: stop_on_error("Model reached an unknown opcode");
			endcase
			if (w[6:0] != OPC_STORE && w[6:0] != OPC_BRANCH && w[11:7] != 5'd0)
				regs[w[11:7]] = res;
			retired++;
			if (w[6:0] == OPC_JAL) begin
				done = (imm_j == 0);
				pc = pc + imm_j;
			end else if (w[6:0] == OPC_BRANCH && a == regs[w[24:20]]) begin
				pc = pc + imm_b;
			end else begin
				pc = pc + 4;
			end
		end
	endtask

	//==================================================
	// Bus models driving inputs on the falling edge

	always @(negedge i_clock) begin
		if (!o_ibus_request) begin
			ibus_pending = 0;
			i_ibus_ready = 0;
		end else begin
			if (i_ibus_ready) begin
				i_ibus_ready = 0;
				ibus_pending = 0;
			end
			if (!ibus_pending) begin
				ibus_pending = 1;
				ibus_wait = 2'(rand_bits(2));
			end
			if (ibus_wait == 0) begin
				i_ibus_ready = 1;
				i_ibus_rdata = word_at(o_ibus_address);
			end else begin
				ibus_wait--;
			end
		end
		if (!o_dbus_request) begin
			dbus_pending = 0;
			i_dbus_ready = 0;
		end else begin
			if (i_dbus_ready) begin
				i_dbus_ready = 0;
				dbus_pending = 0;
			end
			if (!dbus_pending) begin
				dbus_pending = 1;
				dbus_wait = 2'(rand_bits(2));
			end
			if (dbus_wait == 0) begin
				i_dbus_ready = 1;
				i_dbus_rdata = read_dmem(o_dbus_address);
			end else begin
				dbus_wait--;
			end
		end
	end

	// Transfers complete on the rising edge
	always @(posedge i_clock) begin
		logic [31:0] rw, addr, data;
		if (o_retire)
			retire_seen++;
		if (i_rst_n && o_ibus_request && i_ibus_ready) begin
			if (!first_fetch_seen)
				check("first fetch address", RESET_VECTOR, o_ibus_address);
			first_fetch_seen = 1;
			if (in_loop) begin
				check("loop fetch address", jal_addr, o_ibus_address);
				jal_hits++;
			end
		end
		if (o_dbus_request && i_dbus_ready) begin
			if (exp_rw.size() == 0)
				stop_on_error("Data bus transfer came after the last expected store");
			rw = exp_rw.pop_front();
			addr = exp_addr.pop_front();
			data = exp_data.pop_front();
			check("dbus read/write flag", rw, o_dbus_rw);
			check("dbus address", addr, o_dbus_address);
			if (rw[0]) begin
				check("dbus write data", data, o_dbus_wdata);
				dmem[o_dbus_address] = o_dbus_wdata;
			end
			if (exp_rw.size() == 0) begin
				stores_done = 1;
				retire_at_end = retire_seen;
			end
		end
	end

	task automatic apply_reset();
		i_rst_n = 0;
		first_fetch_seen = 0;
		@(negedge i_clock);
		check("ibus request in reset", 0, o_ibus_request);
		check("dbus request in reset", 0, o_dbus_request);
		check("retire in reset", 0, o_retire);
		check("execute busy in reset", 0, o_execute_busy);
		check("memory busy in reset", 0, o_memory_busy);
		check("fault in reset", 0, o_fault);
		@(negedge i_clock);
		i_rst_n = 1;
	endtask

	initial begin
		int n;
		i_clock = 0;
		i_rst_n = 0;
		i_ibus_ready = 0;
		i_dbus_ready = 0;
		i_ibus_rdata = '0;
		i_dbus_rdata = '0;
		lfsr = 32'ha894_fa43;
		{retire_seen, retire_at_end, jal_hits} = '0;
		{stores_done, in_loop} = '0;
		build_main_program();
		run_model();
		apply_reset();
		retire_seen = 0;

		for (n = 0; n < 20000 && !stores_done; n++)
			@(negedge i_clock);
		if (!stores_done)
			stop_on_error("The last store of the program never reached the data bus");
		check("retire pulse count", exp_retire_end, retire_at_end);
		in_loop = 1;
		for (n = 0; n < 2000 && jal_hits < 3; n++)
			@(negedge i_clock);
		if (jal_hits < 3)
			stop_on_error("The JAL loop did not keep fetching its own address");
		check("no fault in main program", 0, o_fault);
		in_loop = 0;

		// Second run with an illegal opcode
		prog_len = 0;
		emit({20'h12345, 5'd1, OPC_LUI});
		emit(32'h0000_007f);
		apply_reset();
		for (n = 0; n < 2000 && !o_fault; n++)
			@(negedge i_clock);
		if (!o_fault)
			stop_on_error("The illegal opcode never raised the fault output");
		for (n = 0; n < 10; n++) begin
			@(negedge i_clock);
			check("fault stays high", 1, o_fault);
		end
		$display("Testbench passed");
		$finish;
	end

endmodule

/* klara_core.f */
src/cpu_pkg.sv
src/cpu_skid_buffer.sv
src/cpu_fetch.sv
src/cpu_registers.sv
src/cpu_csr.sv
src/cpu_execute.sv
src/cpu_memory.sv
src/cpu.sv
bench/cpu_tb.sv

/* Bender.yml */
package:
  name: klara_core

sources:
  - src/cpu_pkg.sv
  - src/cpu_skid_buffer.sv
  - src/cpu_fetch.sv
  - src/cpu_registers.sv
  - src/cpu_csr.sv
  - src/cpu_execute.sv
  - src/cpu_memory.sv
  - src/cpu.sv
  - target: test
    files:
      - bench/cpu_tb.sv
